//--- obi_monitor.f
design/obi_pkg.sv
design/monitor_pkg.sv
design/obi_port_checker.sv
design/monitor_config.sv
design/monitor_status.sv
design/obi_monitor_top.sv
test/tb_obi_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the OBI monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_obi_monitor \
  -f obi_monitor.f \
  -o Vtb_obi_monitor
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_obi_monitor 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- test/obi_monitor_tests.txt
# One step per line, every number in hex
# O port req gnt we addr be wdata rvalid / W offset data bresp / R offset rdata rresp / I cycles / Q irq
# Reset values
R 00 0000000F 0
R 04 0000003F 0
R 08 00000000 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
R 1C 00000000 0
Q 0
# Each rule once on port 1
O 1 1 0 0 00000100 F 00000000 0
O 1 1 0 0 00000104 F 00000000 0
O 1 1 1 0 00000104 F 00000000 0
O 1 0 0 0 00000104 F 00000000 1
O 1 1 0 0 00000200 F 00000000 0
O 1 0 0 0 00000200 F 00000000 0
O 1 0 0 0 00000200 F 00000000 1
O 1 1 1 1 00000300 0 12345678 0
O 1 0 0 0 00000300 0 00000000 1
O 1 1 1 1 00000300 5 00000000 0
O 1 0 0 0 00000300 5 00000000 1
O 1 1 1 0 00000301 1 00000000 0
O 1 0 0 0 00000300 F 00000000 1
O 1 0 0 0 00000000 F 00000000 0
I 3
R 14 0000063F 0
R 10 00000000 0
R 18 00000000 0
R 1C 00000000 0
Q 1
# Interrupt mask and clear
W 08 00000002 0
I 3
Q 0
W 04 00000000 0
O 1 0 0 0 00000000 F 00000000 1
O 1 0 0 0 00000000 F 00000000 0
I 4
Q 0
R 14 00000104 0
W 04 00000004 0
R 04 00000004 0
I 3
Q 1
W 08 00000002 0
I 3
Q 0
R 14 00000000 0
W 04 0000003F 0
# Port 1 disabled then enabled again
W 00 0000000D 0
R 00 0000000D 0
O 1 0 0 0 00000000 F 00000000 1
O 1 1 1 1 00000000 0 00000000 0
O 1 0 0 0 00000000 F 00000000 0
I 3
R 14 00000000 0
Q 0
W 00 0000000F 0
I 2
O 1 0 0 0 00000000 F 00000000 1
O 1 0 0 0 00000000 F 00000000 0
I 3
R 14 00000104 0
Q 1
W 08 00000002 0
I 3
R 14 00000000 0
Q 0
# Error responses leave the registers alone
W 10 12345678 2
W 40 000000FF 2
R 40 00000000 2
R 24 00000000 2
R 00 0000000F 0
R 04 0000003F 0
R 10 00000000 0
R 14 00000000 0
# 300 zero-enable writes on port 2
O 2 1 1 1 00000000 0 00000000 0
I 12B
O 2 0 0 0 00000000 F 00000000 0
I 3
R 18 0000FF08 0
Q 1
W 08 00000004 0
I 3
R 18 00000000 0
Q 0
# Random ports stay clean
R 10 00000000 0
R 1C 00000000 0

//--- test/tb_obi_monitor.sv
// OBI monitor testbench
`timescale 1ns/100ps
`default_nettype none

module tb_obi_monitor
  import obi_pkg::*;
  import monitor_pkg::*;
();

  // Ports 0 and 3 carry LFSR traffic, ports 1 and 2 follow the data file
  localparam port_mask_t RANDOM_PORTS = 4'b1001;
  localparam int         WAIT_LIMIT   = 64;

  logic clk;
  logic reset_n;

  // Scripted and random copies of the OBI inputs
  logic      [NUM_PORTS-1:0] s_req, s_gnt, s_we, s_rvalid;
  obi_addr_t [NUM_PORTS-1:0] s_addr;
  obi_be_t   [NUM_PORTS-1:0] s_be;
  obi_data_t [NUM_PORTS-1:0] s_wdata;
  logic      [NUM_PORTS-1:0] r_req, r_gnt, r_we, r_rvalid;
  obi_addr_t [NUM_PORTS-1:0] r_addr;
  obi_be_t   [NUM_PORTS-1:0] r_be;
  obi_data_t [NUM_PORTS-1:0] r_wdata;

  wire logic      [NUM_PORTS-1:0] obi_req, obi_gnt, obi_we, obi_rvalid;
  wire obi_addr_t [NUM_PORTS-1:0] obi_addr;
  wire obi_be_t   [NUM_PORTS-1:0] obi_be;
  wire obi_data_t [NUM_PORTS-1:0] obi_wdata;

  // AXI4-Lite bus
  axil_addr_t awaddr, araddr;
  axil_data_t wdata, rdata;
  axil_strb_t wstrb;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready, irq;
  resp_t      bresp, rresp;

  // Random traffic state per port
  logic       active   [NUM_PORTS];
  logic       pend     [NUM_PORTS];
  logic [3:0] wait_cnt [NUM_PORTS];
  logic [3:0] gap_cnt  [NUM_PORTS];
  logic [31:0] lfsr_state;

  for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_port_mux
    assign obi_req[g]    = RANDOM_PORTS[g] ? r_req[g]    : s_req[g];
    assign obi_gnt[g]    = RANDOM_PORTS[g] ? r_gnt[g]    : s_gnt[g];
    assign obi_we[g]     = RANDOM_PORTS[g] ? r_we[g]     : s_we[g];
    assign obi_rvalid[g] = RANDOM_PORTS[g] ? r_rvalid[g] : s_rvalid[g];
    assign obi_addr[g]   = RANDOM_PORTS[g] ? r_addr[g]   : s_addr[g];
    assign obi_be[g]     = RANDOM_PORTS[g] ? r_be[g]     : s_be[g];
    assign obi_wdata[g]  = RANDOM_PORTS[g] ? r_wdata[g]  : s_wdata[g];
  end

  obi_monitor_top uut (
    .clk (clk), .reset_n (reset_n),
    .obi_req (obi_req), .obi_gnt (obi_gnt), .obi_addr (obi_addr), .obi_we (obi_we),
    .obi_be (obi_be), .obi_wdata (obi_wdata), .obi_rvalid (obi_rvalid),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .irq (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // -------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    stop_with_failure();
  endtask

  // Inputs change 1 ns after the edge, outputs are stable there too
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = next_lfsr(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic axi_write(input axil_addr_t offset, input axil_data_t data,
                           input resp_t exp_resp);
    int n;
    awaddr  = offset;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    while (!(awready && wready)) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) report_timeout("write address and data ready");
    end
    // Handshake completes on the coming edge
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) report_timeout("write response");
    end
    check_value(32'(bresp), 32'(exp_resp), $sformatf("bresp at offset %h", offset));
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input axil_addr_t offset, input axil_data_t exp_data,
                          input resp_t exp_resp);
    int n;
    araddr  = offset;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    while (!arready) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) report_timeout("read address ready");
    end
    next_cycle();
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) report_timeout("read data");
    end
    check_value(rdata, exp_data, $sformatf("rdata at offset %h", offset));
    check_value(32'(rresp), 32'(exp_resp), $sformatf("rresp at offset %h", offset));
    next_cycle();
    rready = 1'b0;
  endtask

  // -------------------------------------------------------------------
  // Legal background traffic
  // -------------------------------------------------------------------

  // One cycle of a port: gap, request held until gnt, rvalid one cycle later
  task automatic drive_random_port(input logic [1:0] p);
    logic [31:0] bits;
    r_rvalid[p] = pend[p];
    pend[p]     = 1'b0;
    if (!active[p]) begin
      if (gap_cnt[p] == 4'd0) begin
        active[p] = 1'b1;
        rand_bits(2, bits);
        wait_cnt[p] = {2'b00, bits[1:0]};
        rand_bits(30, bits);
        r_addr[p] = {bits[29:0], 2'b00};
        rand_bits(1, bits);
        r_we[p] = bits[0];
        rand_bits(32, bits);
        r_wdata[p] = bits;
        r_be[p] = 4'hF;
      end else begin
        gap_cnt[p] = gap_cnt[p] - 4'd1;
      end
    end
    if (active[p]) begin
      r_req[p] = 1'b1;
      r_gnt[p] = (wait_cnt[p] == 4'd0);
      if (wait_cnt[p] == 4'd0) begin
        pend[p]   = 1'b1;
        active[p] = 1'b0;
        rand_bits(2, bits);
        gap_cnt[p] = {2'b00, bits[1:0]};
      end else begin
        wait_cnt[p] = wait_cnt[p] - 4'd1;
      end
    end else begin
      r_req[p] = 1'b0;
      r_gnt[p] = 1'b0;
    end
  endtask

  initial begin : random_traffic
    int n;
    lfsr_state = 32'h770ea6f5;
    r_req = '0; r_gnt = '0; r_we = '0; r_rvalid = '0;
    r_addr = '0; r_be = '0; r_wdata = '0;
    active   = '{default: 1'b0};
    pend     = '{default: 1'b0};
    wait_cnt = '{default: 4'd0};
    gap_cnt  = '{default: 4'd2};
    n = 0;
    while (reset_n !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) report_timeout("reset release");
    end
    #1;
    forever begin
      drive_random_port(2'd0);
      drive_random_port(2'd3);
      next_cycle();
    end
  end

  // -------------------------------------------------------------------
  // Scripted steps
  // -------------------------------------------------------------------

  initial begin : main_sequence
    int fd;
    int code;
    logic [7:0] cmd;
    logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7;
    logic [8*160-1:0] skip;
    logic [1:0] port;
    bit done;

    reset_n = 1'b0;
    s_req = '0; s_gnt = '0; s_we = '0; s_rvalid = '0;
    s_addr = '0; s_be = '0; s_wdata = '0;
    awaddr = '0; awvalid = 1'b0; wdata = '0; wstrb = '0; wvalid = 1'b0; bready = 1'b0;
    araddr = '0; arvalid = 1'b0; rready = 1'b0;

    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;

    fd = $fopen("test/obi_monitor_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file");
      stop_with_failure();
    end

    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "#": code = $fgets(skip, fd);
          "O": begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6, f7);
            port = f0[1:0];
            if (code != 8 || f0 > 32'd3 || RANDOM_PORTS[port]) begin
              $display("Bad OBI step in the test data file");
              stop_with_failure();
            end
            s_req[port]    = f1[0];
            s_gnt[port]    = f2[0];
            s_we[port]     = f3[0];
            s_addr[port]   = f4;
            s_be[port]     = f5[3:0];
            s_wdata[port]  = f6;
            s_rvalid[port] = f7[0];
            next_cycle();
          end
          "W": begin
            code = $fscanf(fd, "%h %h %h", f0, f1, f2);
            axi_write(f0[7:0], f1, f2[1:0]);
          end
          "R": begin
            code = $fscanf(fd, "%h %h %h", f0, f1, f2);
            axi_read(f0[7:0], f1, f2[1:0]);
          end
          "I": begin
            code = $fscanf(fd, "%h", f0);
            repeat (f0) next_cycle();
          end
          "Q": begin
            code = $fscanf(fd, "%h", f0);
            check_value(32'(irq), f0, "irq level");
          end
          default: begin
            $display("Unknown step in the test data file");
            stop_with_failure();
          end
        endcase
      end
    end
    $fclose(fd);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/obi_monitor_top.sv
// OBI protocol monitor top
`timescale 1ns/100ps
`default_nettype none

module obi_monitor_top
  import obi_pkg::*;
  import monitor_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset_n,

  // Observed OBI ports, one element per port
  input  logic      [NUM_PORTS-1:0] obi_req,
  input  logic      [NUM_PORTS-1:0] obi_gnt,
  input  obi_addr_t [NUM_PORTS-1:0] obi_addr,
  input  logic      [NUM_PORTS-1:0] obi_we,
  input  obi_be_t   [NUM_PORTS-1:0] obi_be,
  input  obi_data_t [NUM_PORTS-1:0] obi_wdata,
  input  logic      [NUM_PORTS-1:0] obi_rvalid,

  // AXI4-Lite slave
  input  axil_addr_t                awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  axil_data_t                wdata,
  input  axil_strb_t                wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output resp_t                     bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  axil_addr_t                araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output axil_data_t                rdata,
  output resp_t                     rresp,
  output logic                      rvalid,
  input  logic                      rready,

  output logic                      irq
);

  port_mask_t                port_en;
  rule_vec_t                 rule_mask;
  port_mask_t                clear;
  rule_vec_t [NUM_PORTS-1:0] violation;

  // Write side owns the enables and the clear strobes
  monitor_config u_config (
    .clk       (clk),
    .reset_n   (reset_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .port_en   (port_en),
    .rule_mask (rule_mask),
    .clear     (clear)
  );

  // -------------------------------------------------------------------
  // One checker per port
  // -------------------------------------------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_checker
    obi_port_checker u_checker (
      .clk       (clk),
      .reset_n   (reset_n),
      .port_en   (port_en[p]),
      .req       (obi_req[p]),
      .gnt       (obi_gnt[p]),
      .addr      (obi_addr[p]),
      .we        (obi_we[p]),
      .be        (obi_be[p]),
      .wdata     (obi_wdata[p]),
      .rvalid    (obi_rvalid[p]),
      .violation (violation[p])
    );
  end

  // Read side collects the pulses
  monitor_status u_status (
    .clk       (clk),
    .reset_n   (reset_n),
    .violation (violation),
    .port_en   (port_en),
    .rule_mask (rule_mask),
    .clear     (clear),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .irq       (irq)
  );

endmodule

`default_nettype wire

//--- design/monitor_status.sv
// Violation status and read channel
`timescale 1ns/100ps
`default_nettype none

module monitor_status
  import obi_pkg::*;
  import monitor_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset_n,
  input  rule_vec_t [NUM_PORTS-1:0]  violation,
  input  port_mask_t                 port_en,
  input  rule_vec_t                  rule_mask,
  input  port_mask_t                 clear,
  input  axil_addr_t                 araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output axil_data_t                 rdata,
  output resp_t                      rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output logic                       irq
);

  rule_vec_t    sticky [NUM_PORTS];
  event_count_t count  [NUM_PORTS];

  logic         irq_next;
  logic         ar_fire;
  axil_data_t   rd_data;
  resp_t        rd_resp;

  // -------------------------------------------------------------------
  // Sticky flags and counters
  // -------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        sticky[p] <= '0;
        count[p]  <= '0;
      end
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        // Clear wins over a pulse in the same cycle
        if (clear[p]) begin
          sticky[p] <= '0;
          count[p]  <= '0;
        end else if (violation[p] != '0) begin
          sticky[p] <= sticky[p] | violation[p];
          // One count per cycle, however many rules fired
          if (count[p] != COUNT_MAX) begin
            count[p] <= count[p] + event_count_t'(1);
          end
        end
      end
    end
  end

  // Any enabled rule seen on any port
  always_comb begin
    irq_next = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      irq_next = irq_next | ((sticky[p] & rule_mask) != '0);
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      irq <= 1'b0;
    end else begin
      irq <= irq_next;
    end
  end

  // -------------------------------------------------------------------
  // Read channel
  // -------------------------------------------------------------------

  // Address decode; REG_CLEAR is write-only and reads as zero
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_SLVERR;
    if (araddr == REG_PORT_EN) begin
      rd_data = axil_data_t'(port_en);
      rd_resp = RESP_OKAY;
    end else if (araddr == REG_RULE_MASK) begin
      rd_data = axil_data_t'(rule_mask);
      rd_resp = RESP_OKAY;
    end else if (araddr == REG_CLEAR) begin
      rd_resp = RESP_OKAY;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (araddr == axil_addr_t'(REG_STATUS_BASE + p * STATUS_STRIDE)) begin
        rd_data[NUM_RULES-1:0] = sticky[p];
        rd_data[STATUS_COUNT_LSB +: $bits(event_count_t)] = count[p];
        rd_resp = RESP_OKAY;
      end
    end
  end

  assign ar_fire = arvalid && arready;

  // arready mirrors !rvalid once out of reset
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (ar_fire) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end else if (rvalid && rready) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else if (!rvalid) begin
      arready <= 1'b1;
    end
  end

  // Read payload captured at acceptance
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

endmodule

`default_nettype wire

//--- design/monitor_config.sv
// Monitor write channel and configuration
`timescale 1ns/100ps
`default_nettype none

module monitor_config
  import obi_pkg::*;
  import monitor_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  input  logic       wvalid,
  output logic       wready,
  output resp_t      bresp,
  output logic       bvalid,
  input  logic       bready,
  output port_mask_t port_en,
  output rule_vec_t  rule_mask,
  output port_mask_t clear
);

  logic wr_start;
  logic wr_fire;
  logic wr_mapped;

  // -------------------------------------------------------------------
  // Write handshake
  // -------------------------------------------------------------------

  // Address and data taken together, never while a response is pending
  assign wr_start = awvalid && wvalid && !bvalid && !awready;
  assign wr_fire  = awready && awvalid && wvalid;

  // Status words and unused offsets are not writable
  assign wr_mapped = (awaddr == REG_PORT_EN) || (awaddr == REG_RULE_MASK) ||
                     (awaddr == REG_CLEAR);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end else begin
      // Single-cycle ready pulse
      awready <= wr_start;
      wready  <= wr_start;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
      bresp  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // -------------------------------------------------------------------
  // Configuration registers
  // -------------------------------------------------------------------

  // Only byte lane 0 carries the fields
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      port_en   <= '1;
      rule_mask <= '1;
    end else if (wr_fire && wstrb[0]) begin
      if (awaddr == REG_PORT_EN) begin
        port_en <= wdata[NUM_PORTS-1:0];
      end
      if (awaddr == REG_RULE_MASK) begin
        rule_mask <= wdata[NUM_RULES-1:0];
      end
    end
  end

  // Clear strobes are live in the handshake cycle and act on the write edge
  assign clear = (wr_fire && wstrb[0] && awaddr == REG_CLEAR) ?
                 wdata[NUM_PORTS-1:0] : '0;

endmodule

`default_nettype wire

//--- design/obi_port_checker.sv
// OBI port rule checker
`timescale 1ns/100ps
`default_nettype none

module obi_port_checker
  import obi_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      port_en,
  input  logic      req,
  input  logic      gnt,
  input  obi_addr_t addr,
  input  logic      we,
  input  obi_be_t   be,
  input  obi_data_t wdata,
  input  logic      rvalid,
  output rule_vec_t violation
);

  // -------------------------------------------------------------------
  // Previous cycle of the A channel
  // -------------------------------------------------------------------

  logic         prev_req;
  logic         prev_gnt;
  obi_addr_t    prev_addr;
  logic         prev_we;
  obi_be_t      prev_be;
  obi_data_t    prev_wdata;

  outstanding_t outstanding;
  rule_vec_t    viol_next;

  logic         a_accept;
  logic         wait_gnt;
  logic         a_changed;

  // Enables that form a single run of ones
  function automatic logic be_contiguous(input obi_be_t be_in);
    case (be_in)
      4'b0001, 4'b0011, 4'b0111, 4'b1111,
      4'b0010, 4'b0110, 4'b1110,
      4'b0100, 4'b1100,
      4'b1000: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Byte lane of the lowest set enable
  function automatic logic [1:0] lowest_be_lane(input obi_be_t be_in);
    casez (be_in)
      4'b???1: return 2'd0;
      4'b??10: return 2'd1;
      4'b?100: return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  // Handshake bookkeeping; req is masked so a re-enabled port starts clean
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      prev_req <= 1'b0;
      prev_gnt <= 1'b0;
    end else begin
      prev_req <= req && port_en;
      prev_gnt <= gnt;
    end
  end

  // A-phase fields only matter while prev_req is set
  always_ff @(posedge clk) begin
    prev_addr  <= addr;
    prev_we    <= we;
    prev_be    <= be;
    prev_wdata <= wdata;
  end

  // -------------------------------------------------------------------
  // Outstanding transaction model
  // -------------------------------------------------------------------

  assign a_accept = req && gnt;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      outstanding <= '0;
    end else if (!port_en) begin
      outstanding <= '0;
    end else if (a_accept && !rvalid) begin
      // Hold at the top rather than wrap
      if (outstanding != '1) begin
        outstanding <= outstanding + outstanding_t'(1);
      end
    end else if (!a_accept && rvalid && outstanding != '0) begin
      outstanding <= outstanding - outstanding_t'(1);
    end
  end

  // -------------------------------------------------------------------
  // Rule evaluation
  // -------------------------------------------------------------------

  // Last cycle had a request still waiting for its grant
  assign wait_gnt  = prev_req && !prev_gnt;
  assign a_changed = (addr != prev_addr) || (we != prev_we) ||
                     (be != prev_be) || (wdata != prev_wdata);

  always_comb begin
    viol_next = '0;
    viol_next[RULE_STABLE]     = wait_gnt && a_changed;
    viol_next[RULE_REQ_HOLD]   = wait_gnt && !req;
    // Also catches rvalid in the same cycle as the first grant
    viol_next[RULE_R_BEFORE_A] = rvalid && (outstanding == '0);
    viol_next[RULE_BE_ZERO]    = req && we && (be == '0);
    // Zero enables are left to RULE_BE_ZERO
    viol_next[RULE_BE_GAP]     = req && we && (be != '0) && !be_contiguous(be);
    viol_next[RULE_ADDR_BE]    = req && (be != '0) && (addr[1:0] != lowest_be_lane(be));
  end

  // One-cycle pulse, silent while the port is disabled
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      violation <= '0;
    end else if (port_en) begin
      violation <= viol_next;
    end else begin
      violation <= '0;
    end
  end

endmodule

`default_nettype wire

//--- design/monitor_pkg.sv
// Monitor register map
`default_nettype none

package monitor_pkg;

  // Number of observed OBI ports
  localparam int unsigned NUM_PORTS = 4;

  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // -------------------------------------------------------------------
  // AXI4-Lite slave widths
  // -------------------------------------------------------------------

  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;

  // Violation cycles seen on one port, held at the top value
  typedef logic [7:0]  event_count_t;
  localparam event_count_t COUNT_MAX = 8'hFF;

  // -------------------------------------------------------------------
  // Register offsets
  // -------------------------------------------------------------------

  localparam axil_addr_t REG_PORT_EN     = 8'h00;
  localparam axil_addr_t REG_RULE_MASK   = 8'h04;
  localparam axil_addr_t REG_CLEAR       = 8'h08;
  localparam axil_addr_t REG_STATUS_BASE = 8'h10;

  // One status word per port
  localparam int unsigned STATUS_STRIDE    = 4;

  // Counter field in a status word, sticky rule bits start at bit 0
  localparam int unsigned STATUS_COUNT_LSB = 8;

  // AXI response codes
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- design/obi_pkg.sv
// OBI port definitions
`default_nettype none

package obi_pkg;

  // -------------------------------------------------------------------
  // OBI 1.1 port widths
  // -------------------------------------------------------------------

  // Byte address as seen on the A channel
  typedef logic [31:0] obi_addr_t;
  typedef logic [31:0] obi_data_t;

  // One enable per data byte
  typedef logic [3:0]  obi_be_t;

  // Accepted address phases still waiting for rvalid
  typedef logic [3:0]  outstanding_t;

  // -------------------------------------------------------------------
  // Checked rules
  // -------------------------------------------------------------------

  localparam int unsigned NUM_RULES = 6;

  typedef logic [NUM_RULES-1:0] rule_vec_t;

  // Bit positions in rule_vec_t
  localparam int unsigned RULE_STABLE     = 0;  // A-phase changed while waiting for gnt
  localparam int unsigned RULE_REQ_HOLD   = 1;  // req withdrawn before gnt
  localparam int unsigned RULE_R_BEFORE_A = 2;  // rvalid with nothing outstanding
  localparam int unsigned RULE_BE_ZERO    = 3;  // write with no enable set
  localparam int unsigned RULE_BE_GAP     = 4;  // write enables not contiguous
  localparam int unsigned RULE_ADDR_BE    = 5;  // addr[1:0] against lowest enable

endpackage

`default_nettype wire
